//--- dv/arcade_input_tb.sv
/*
 * arcade input testbench
 * random stimulus against a cycle model of the settings registers,
 * snac decode and routing, coin pulse, credits toggle and reset hold
 */

`timescale 1ns/100ps

`include "arcade_input_consts.svh"

module arcade_input_tb import arcade_input_pkg::*; ();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 2;
    localparam int SETTINGS_CYCLES = 400;
    localparam int PASS_CYCLES     = 100;
    localparam int ROUTE_CYCLES    = 60;
    localparam int COIN_CYCLES     = 400;
    localparam int CREDIT_CYCLES   = 200;
    localparam int WRITE_CYCLES    = 2 * 20;
    localparam int HOLD_TEST       = 2 * `RESET_HOLD_CYCLES + 40;
    localparam int TOTAL_CYCLES    = 2 * RESET_CYCLES + SETTINGS_CYCLES + 2 * PASS_CYCLES +
                                     12 * ROUTE_CYCLES + COIN_CYCLES + CREDIT_CYCLES +
                                     WRITE_CYCLES + HOLD_TEST;
    localparam int MARGIN_CYCLES   = 100;

    // stimulus flavours
    localparam int K_SETTINGS = 0;
    localparam int K_PASS     = 1;
    localparam int K_ROUTE    = 2;
    localparam int K_COIN     = 3;
    localparam int K_CREDIT   = 4;

    logic         clk_74a = 1'b0;
    logic         reset;
    bus_addr_t    bridge_addr;
    logic         bridge_wr;
    bus_data_t    bridge_wr_data;
    bus_data_t    bridge_rd_data;
    key_word_t    cont1_key;
    key_word_t    cont2_key;
    key_word_t    snac_p1_btn;
    joy_word_t    snac_p1_joy;
    key_word_t    snac_p2_btn;
    joy_word_t    snac_p2_joy;
    key_word_t    p1_controls;
    key_word_t    p2_controls;
    arcade_ctrl_t game_controls;
    logic         credits_pause;
    dip_word_t    dip_switches;
    logic         core_reset;

    // reference model state
    logic [1:0]   m_lives = '0;
    logic [2:0]   m_diff = '0;
    logic [2:0]   m_bonus = '0;
    logic         m_demo = 1'b0;
    logic         m_ena = 1'b0;
    cont_type_t   m_type = '0;
    logic [1:0]   m_mode = '0;
    key_word_t    m_dec1 = '0;
    key_word_t    m_dec2 = '0;
    key_word_t    m_p1 = '0;
    key_word_t    m_p2 = '0;
    logic [5:0]   m_ctrl = '0;
    logic         m_coin_prev = 1'b0;
    int           m_coin_left = 0;
    logic         m_r1_prev1 = 1'b0;
    logic         m_r1_prev2 = 1'b0;
    logic         m_credits = 1'b0;
    int           m_hold_left = 0;

    logic check_en = 1'b0;
    // slow-moving levels for coin and r1 stimulus
    logic coin_level = 1'b0;
    logic r1_level1 = 1'b0;
    logic r1_level2 = 1'b0;
    int   coin_run = 0;
    int   hold_run = 0;
    int   coin_runs_seen = 0;
    int   hold_runs_seen = 0;

    always #(CLK_PERIOD / 2) clk_74a = ~clk_74a;

    arcade_input_top i_arcade_input_top (.*);

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    ////////////////////
    // model rules
    ////////////////////

    // exact 0x40 and 0xc0 stay centred
    function automatic key_word_t stick_decode(input key_word_t btn, input joy_word_t joy,
                                               input logic analog);
        key_word_t res;
        res = btn;
        if (analog) begin
            res[0] = joy[15:8] < 8'h40;
            res[1] = joy[15:8] > 8'hC0;
            res[2] = joy[7:0] < 8'h40;
            res[3] = joy[7:0] > 8'hC0;
        end
        return res;
    endfunction

    // p1 word in the upper half and p2 word in the lower half
    function automatic logic [31:0] route_players(input key_word_t c1, input key_word_t c2,
                                                  input key_word_t s1, input key_word_t s2);
        if (!m_ena || m_type == 5'd0) begin
            return {c1, c2};
        end
        case (m_mode)
            2'd0: return {s1, c1};
            2'd1: return {c1, s1};
            2'd2: return {s1, s2};
            default: return {s2, s1};
        endcase
    endfunction

    function automatic bus_data_t expected_read(input bus_addr_t addr);
        bus_data_t data;
        data = '0;
        if (addr == `ADDR_SNAC_ENABLE) begin
            data[0] = m_ena;
        end else if (addr == `ADDR_SNAC_CONFIG) begin
            data[4:0] = m_type;
            data[9:8] = m_mode;
        end
        return data;
    endfunction

    // upper byte 00 ddd bbb and lower byte m0 ll 0000
    function automatic dip_word_t expected_dip();
        dip_word_t dip;
        dip        = '0;
        dip[13:11] = m_diff;
        dip[10:8]  = m_bonus;
        dip[7]     = m_demo;
        dip[5:4]   = m_lives;
        return dip;
    endfunction

    // one step per edge with later stages first so they see last cycle's values
    always @(posedge clk_74a) begin
        logic [31:0] routed;
        logic        analog_now;
        analog_now = (m_type == 5'h12) || (m_type == 5'h13);
        routed     = route_players(cont1_key, cont2_key, m_dec1, m_dec2);
        if (reset) begin
            m_lives = '0;
            m_diff = '0;
            m_bonus = '0;
            m_demo = 1'b0;
            m_ena = 1'b0;
            m_type = '0;
            m_mode = '0;
            m_dec1 = '0;
            m_dec2 = '0;
            m_p1 = '0;
            m_p2 = '0;
            m_ctrl = '0;
            m_coin_prev = 1'b0;
            m_coin_left = 0;
            m_r1_prev1 = 1'b0;
            m_r1_prev2 = 1'b0;
            m_credits = 1'b0;
            m_hold_left = 0;
        end else begin
            // arcade side uses last cycle's player words
            m_ctrl[5] = m_p1[0];
            m_ctrl[4] = m_p1[1];
            m_ctrl[3] = m_p1[2];
            m_ctrl[2] = m_p1[3];
            m_ctrl[1] = m_p1[4];
            m_ctrl[0] = m_p1[15];
            if (m_coin_left != 0) begin
                m_coin_left--;
            end else if (m_coin_prev && !m_p1[14]) begin
                m_coin_left = `COIN_PULSE_CYCLES;
            end
            m_coin_prev = m_p1[14];
            if ((m_p1[9] && !m_r1_prev1) || (m_p2[9] && !m_r1_prev2)) begin
                m_credits = !m_credits;
            end
            m_r1_prev1 = m_p1[9];
            m_r1_prev2 = m_p2[9];
            m_p1 = routed[31:16];
            m_p2 = routed[15:0];
            m_dec1 = stick_decode(snac_p1_btn, snac_p1_joy, analog_now);
            m_dec2 = stick_decode(snac_p2_btn, snac_p2_joy, analog_now);
            // manual reset hold
            if (m_hold_left != 0) begin
                m_hold_left--;
            end else if (bridge_wr && bridge_addr == `ADDR_MANUAL_RESET) begin
                m_hold_left = `RESET_HOLD_CYCLES;
            end
            if (bridge_wr) begin
                case (bridge_addr)
                    `ADDR_LIVES:       m_lives = bridge_wr_data[1:0];
                    `ADDR_DIFFICULTY:  m_diff = bridge_wr_data[2:0];
                    `ADDR_BONUS:       m_bonus = bridge_wr_data[2:0];
                    `ADDR_DEMO_SOUNDS: m_demo = bridge_wr_data[0];
                    `ADDR_SNAC_ENABLE: m_ena = bridge_wr_data[0];
                    `ADDR_SNAC_CONFIG: begin
                        m_type = bridge_wr_data[4:0];
                        m_mode = bridge_wr_data[9:8];
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // checker at mid-cycle
    ////////////////////

    always @(negedge clk_74a) begin
        if (check_en) begin
            check_equal(p1_controls, m_p1, "p1_controls");
            check_equal(p2_controls, m_p2, "p2_controls");
            check_equal(game_controls, {m_ctrl, m_coin_left != 0}, "game_controls");
            check_equal(credits_pause, m_credits, "credits_pause");
            check_equal(dip_switches, expected_dip(), "dip_switches");
            check_equal(bridge_rd_data, expected_read(bridge_addr), "bridge_rd_data");
            check_equal(core_reset, reset || m_hold_left != 0, "core_reset");
            // pulse widths measured straight off the outputs
            if (reset) begin
                coin_run = 0;
                hold_run = 0;
            end else begin
                if (game_controls[0]) begin
                    coin_run++;
                end else if (coin_run != 0) begin
                    check_equal(coin_run, `COIN_PULSE_CYCLES, "coin pulse length");
                    coin_runs_seen++;
                    coin_run = 0;
                end
                if (core_reset) begin
                    hold_run++;
                end else if (hold_run != 0) begin
                    check_equal(hold_run, `RESET_HOLD_CYCLES, "core_reset hold length");
                    hold_runs_seen++;
                    hold_run = 0;
                end
            end
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    function automatic bus_addr_t pick_addr();
        case ($urandom % 10)
            0: return `ADDR_LIVES;
            1: return `ADDR_DIFFICULTY;
            2: return `ADDR_BONUS;
            3: return `ADDR_DEMO_SOUNDS;
            4: return `ADDR_SNAC_ENABLE;
            5: return `ADDR_SNAC_CONFIG;
            6: return `ADDR_MANUAL_RESET;
            // near miss on a listed address
            7: return `ADDR_SNAC_CONFIG + 32'd4;
            8: return $urandom;
            default: return '0;
        endcase
    endfunction

    // biased towards the threshold edges
    function automatic axis_t pick_axis();
        case ($urandom % 8)
            0: return 8'h40;
            1: return 8'hC0;
            2: return 8'h3F;
            3: return 8'h41;
            4: return 8'hBF;
            5: return 8'hC1;
            default: return $urandom;
        endcase
    endfunction

    function automatic bus_data_t make_config(input cont_type_t ctype, input logic [1:0] mode);
        bus_data_t data;
        data = '0;
        data[`SNAC_TYPE_LSB +: 5]   = ctype;
        data[`SNAC_ASSIGN_LSB +: 2] = mode;
        return data;
    endfunction

    task automatic bridge_write(input bus_addr_t addr, input bus_data_t data);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr      <= 1'b1;
        bridge_wr_data <= data;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
    endtask

    task automatic run_cycles(input int n, input int kind);
        key_word_t k1;
        key_word_t k2;
        joy_word_t j1;
        joy_word_t j2;
        int        i;
        for (i = 0; i < n; i++) begin
            @(posedge clk_74a);
            k1 = $urandom;
            k2 = $urandom;
            j1 = $urandom;
            j2 = $urandom;
            if (kind == K_ROUTE) begin
                j1[7:0]  = pick_axis();
                j1[15:8] = pick_axis();
                j2[7:0]  = pick_axis();
                j2[15:8] = pick_axis();
            end
            if (kind == K_COIN) begin
                if ($urandom % 3 == 0) begin
                    coin_level = !coin_level;
                end
                k1[14] = coin_level;
            end
            if (kind == K_CREDIT) begin
                if ($urandom % 3 == 0) begin
                    r1_level1 = !r1_level1;
                end
                if ($urandom % 4 == 0) begin
                    r1_level2 = !r1_level2;
                end
                k1[9] = r1_level1;
                k2[9] = r1_level2;
            end
            cont1_key      <= k1;
            cont2_key      <= k2;
            snac_p1_btn    <= $urandom;
            snac_p2_btn    <= $urandom;
            snac_p1_joy    <= j1;
            snac_p2_joy    <= j2;
            bridge_addr    <= pick_addr();
            bridge_wr      <= (kind == K_SETTINGS) && ($urandom % 2 == 1);
            bridge_wr_data <= $urandom;
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        cont_type_t ctype;
        int         mode;
        int         t;
        void'($urandom(24));
        reset          = 1'b1;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        snac_p1_btn    = '0;
        snac_p1_joy    = '0;
        snac_p2_btn    = '0;
        snac_p2_joy    = '0;
        repeat (RESET_CYCLES) @(posedge clk_74a);
        reset <= 1'b0;
        check_en = 1'b1;

        // settings registers and read mux
        run_cycles(SETTINGS_CYCLES, K_SETTINGS);

        // passthrough with enable low then type none
        bridge_write(`ADDR_SNAC_CONFIG, make_config(`SNAC_TYPE_ANALOG_A, snac_both));
        bridge_write(`ADDR_SNAC_ENABLE, 32'd0);
        run_cycles(PASS_CYCLES, K_PASS);
        bridge_write(`ADDR_SNAC_CONFIG, make_config(`SNAC_TYPE_NONE, snac_swapped));
        bridge_write(`ADDR_SNAC_ENABLE, 32'd1);
        run_cycles(PASS_CYCLES, K_PASS);

        // every mode with a digital pad and both analog pads
        for (mode = 0; mode < 4; mode++) begin
            for (t = 0; t < 3; t++) begin
                if (t == 0) begin
                    ctype = 5'h01 + 5'($urandom % 17);
                end else if (t == 1) begin
                    ctype = `SNAC_TYPE_ANALOG_A;
                end else begin
                    ctype = `SNAC_TYPE_ANALOG_B;
                end
                bridge_write(`ADDR_SNAC_CONFIG, make_config(ctype, 2'(mode)));
                run_cycles(ROUTE_CYCLES, K_ROUTE);
            end
        end

        // coin releases from the pocket keys
        bridge_write(`ADDR_SNAC_ENABLE, 32'd0);
        run_cycles(COIN_CYCLES, K_COIN);

        // manual reset with a second write inside the hold
        bridge_write(`ADDR_MANUAL_RESET, $urandom);
        run_cycles(10, K_CREDIT);
        bridge_write(`ADDR_MANUAL_RESET, $urandom);
        run_cycles(`RESET_HOLD_CYCLES + 10, K_CREDIT);
        run_cycles(CREDIT_CYCLES, K_CREDIT);

        // release r1 on both players, then set the credits flag if it is clear
        @(posedge clk_74a);
        cont1_key[9] <= 1'b0;
        cont2_key[9] <= 1'b0;
        repeat (3) @(posedge clk_74a);
        @(negedge clk_74a);
        if (!credits_pause) begin
            @(posedge clk_74a);
            cont1_key[9] <= 1'b1;
            repeat (2) @(posedge clk_74a);
            @(negedge clk_74a);
        end
        check_equal(credits_pause, 1'b1, "credits_pause before reset");

        // board reset clears the credits flag
        @(posedge clk_74a);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_74a);
        reset <= 1'b0;
        @(negedge clk_74a);
        check_equal(credits_pause, 1'b0, "credits_pause after reset");
        run_cycles(20, K_CREDIT);

        check_equal(coin_runs_seen != 0, 1'b1, "coin pulse observed");
        check_equal(hold_runs_seen != 0, 1'b1, "reset hold observed");
        repeat (2) @(posedge clk_74a);
        $display("Simulation finished: PASS");
        $finish;
    end

    // watchdog
    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: test sequence still running after %0d cycles",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- include/arcade_input_consts.svh
/*
 * arcade input constants
 * bridge addresses, snac config fields, stick thresholds and timer lengths
 */

`ifndef ARCADE_INPUT_CONSTS_SVH
`define ARCADE_INPUT_CONSTS_SVH

////////////////////
// bridge addresses
////////////////////

`define ADDR_LIVES          32'h2000_0000
`define ADDR_DIFFICULTY     32'h3000_0000
`define ADDR_BONUS          32'h4000_0000
`define ADDR_DEMO_SOUNDS    32'h5000_0000
`define ADDR_SNAC_ENABLE    32'hF200_0000
`define ADDR_SNAC_CONFIG    32'hF700_0000
`define ADDR_MANUAL_RESET   32'h8000_0000

// snac config word, type in 4:0, assignment in 9:8
`define SNAC_TYPE_LSB       0
`define SNAC_ASSIGN_LSB     8

////////////////////
// stick and controller
////////////////////

// left stick idles near 0x7f
`define STICK_LOW           8'h40
`define STICK_HIGH          8'hC0

`define SNAC_TYPE_NONE      5'h00
`define SNAC_TYPE_ANALOG_A  5'h12
`define SNAC_TYPE_ANALOG_B  5'h13

////////////////////
// timers, in clk_74a cycles
////////////////////

`define COIN_PULSE_CYCLES   16
`define RESET_HOLD_CYCLES   32

`endif

//--- logic/arcade_controls.sv
/*
 * arcade controls
 * game input word from player 1, stretched coin pulse
 * and the r1 credits-pause toggle
 */

`timescale 1ns/100ps

`include "arcade_input_consts.svh"

module arcade_controls import arcade_input_pkg::*; (
    input  logic         clk_74a,
    input  logic         reset,
    input  key_word_t    p1_controls,
    input  key_word_t    p2_controls,
    output arcade_ctrl_t game_controls,
    output logic         credits_pause
);

    localparam int PULSE_W = $clog2(`COIN_PULSE_CYCLES + 1);

    logic [5:0]         ctrl_q;
    logic               coin_prev;
    logic               coin_fall;
    logic [PULSE_W-1:0] pulse_cnt;
    logic               coin_pulse;
    logic               p1_r1_prev;
    logic               p2_r1_prev;
    logic               r1_rise;

    ////////////////////
    // direction, fire, start
    ////////////////////

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            ctrl_q <= '0;
        end else begin
            // up down left right fire start
            ctrl_q <= {p1_controls[0], p1_controls[1], p1_controls[2],
                       p1_controls[3], p1_controls[4], p1_controls[15]};
        end
    end

    ////////////////////
    // coin pulse
    ////////////////////

    // coin counts on release of select
    assign coin_fall = coin_prev && !p1_controls[14];

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            coin_prev <= 1'b0;
            pulse_cnt <= '0;
        end else begin
            coin_prev <= p1_controls[14];
            if (pulse_cnt != '0) begin
                // busy, new releases dropped
                pulse_cnt <= pulse_cnt - 1'b1;
            end else if (coin_fall) begin
                pulse_cnt <= PULSE_W'(`COIN_PULSE_CYCLES);
            end
        end
    end

    assign coin_pulse = pulse_cnt != '0;

    assign game_controls = {ctrl_q, coin_pulse};

    ////////////////////
    // credits pause
    ////////////////////

    // r1 on either player flips it
    assign r1_rise = (p1_controls[9] && !p1_r1_prev) || (p2_controls[9] && !p2_r1_prev);

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_r1_prev    <= 1'b0;
            p2_r1_prev    <= 1'b0;
            credits_pause <= 1'b0;
        end else begin
            p1_r1_prev <= p1_controls[9];
            p2_r1_prev <= p2_controls[9];
            if (r1_rise) begin
                credits_pause <= !credits_pause;
            end
        end
    end

    a_pulse_bound: assert property (@(posedge clk_74a) disable iff (reset)
        pulse_cnt <= PULSE_W'(`COIN_PULSE_CYCLES));

endmodule

//--- logic/arcade_input_pkg.sv
/*
 * arcade input package
 * shared types for the player control path and the settings block
 */

package arcade_input_pkg;

    // pocket / snac button bitmap
    // 0-3 up down left right, 4 a, 9 r1, 14 select (coin), 15 start
    typedef logic [15:0] key_word_t;

    // stick word, left x in 7:0 and left y in 15:8
    typedef logic [31:0] joy_word_t;

    // one unsigned stick axis
    typedef logic [7:0] axis_t;

    // snac controller type code
    typedef logic [4:0] cont_type_t;

    // which snac port feeds which player
    typedef enum logic [1:0] {
        snac1_to_p1  = 2'd0,
        snac1_to_p2  = 2'd1,
        snac_both    = 2'd2,
        snac_swapped = 2'd3
    } assign_mode_t;

    // game control input, up down left right fire start coin
    typedef logic [6:0] arcade_ctrl_t;

    // dip word as the game sees it
    typedef logic [15:0] dip_word_t;

    // bridge bus
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

endpackage

//--- logic/arcade_input_top.sv
/*
 * arcade input top
 * settings block, two snac decoders, player router and arcade controls
 */

`timescale 1ns/100ps

module arcade_input_top import arcade_input_pkg::*; (
    input  logic         clk_74a,
    input  logic         reset,
    // bridge
    input  bus_addr_t    bridge_addr,
    input  logic         bridge_wr,
    input  bus_data_t    bridge_wr_data,
    output bus_data_t    bridge_rd_data,
    // pocket controllers
    input  key_word_t    cont1_key,
    input  key_word_t    cont2_key,
    // snac ports, already decoded from the cart port
    input  key_word_t    snac_p1_btn,
    input  joy_word_t    snac_p1_joy,
    input  key_word_t    snac_p2_btn,
    input  joy_word_t    snac_p2_joy,
    // to the game
    output key_word_t    p1_controls,
    output key_word_t    p2_controls,
    output arcade_ctrl_t game_controls,
    output logic         credits_pause,
    output dip_word_t    dip_switches,
    output logic         core_reset
);

    key_word_t snac1_decoded;
    key_word_t snac2_decoded;

    snac_cfg_if cfg_bus ();

    core_settings i_core_settings (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cfg            (cfg_bus.settings_src),
        .dip_switches   (dip_switches),
        .core_reset     (core_reset)
    );

    ////////////////////
    // snac decode, one per port
    ////////////////////

    snac_dpad_decode snac_p1_decode (
        .clk_74a     (clk_74a),
        .reset       (reset),
        .cfg         (cfg_bus.decode),
        .snac_btn    (snac_p1_btn),
        .snac_joy    (snac_p1_joy),
        .decoded_btn (snac1_decoded)
    );

    snac_dpad_decode snac_p2_decode (
        .clk_74a     (clk_74a),
        .reset       (reset),
        .cfg         (cfg_bus.decode),
        .snac_btn    (snac_p2_btn),
        .snac_joy    (snac_p2_joy),
        .decoded_btn (snac2_decoded)
    );

    player_route i_player_route (
        .clk_74a     (clk_74a),
        .reset       (reset),
        .cfg         (cfg_bus.route),
        .cont1_key   (cont1_key),
        .cont2_key   (cont2_key),
        .snac1       (snac1_decoded),
        .snac2       (snac2_decoded),
        .p1_controls (p1_controls),
        .p2_controls (p2_controls)
    );

    arcade_controls i_arcade_controls (
        .clk_74a       (clk_74a),
        .reset         (reset),
        .p1_controls   (p1_controls),
        .p2_controls   (p2_controls),
        .game_controls (game_controls),
        .credits_pause (credits_pause)
    );

endmodule

//--- logic/core_settings.sv
/*
 * core settings
 * bridge-written dip and snac registers, read mux,
 * dip word assembly and the manual reset hold timer
 */

`timescale 1ns/100ps

`include "arcade_input_consts.svh"

module core_settings import arcade_input_pkg::*; (
    input  logic           clk_74a,
    input  logic           reset,
    input  bus_addr_t      bridge_addr,
    input  logic           bridge_wr,
    input  bus_data_t      bridge_wr_data,
    output bus_data_t      bridge_rd_data,
    snac_cfg_if.settings_src cfg,
    output dip_word_t      dip_switches,
    output logic           core_reset
);

    localparam int HOLD_W = $clog2(`RESET_HOLD_CYCLES);

    logic [1:0]   lives;
    logic [2:0]   difficulty;
    logic [2:0]   bonus;
    logic         demo_sounds;
    logic         snac_ena_q;
    cont_type_t   cont_type_q;
    assign_mode_t assign_mode_q;

    logic              hold_active;
    logic [HOLD_W-1:0] hold_cnt;
    logic              reset_wr;

    ////////////////////
    // setting registers
    ////////////////////

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            lives         <= '0;
            difficulty    <= '0;
            bonus         <= '0;
            demo_sounds   <= 1'b0;
            snac_ena_q    <= 1'b0;
            cont_type_q   <= `SNAC_TYPE_NONE;
            assign_mode_q <= snac1_to_p1;
        end else if (bridge_wr) begin
            // unlisted addresses fall through untouched
            case (bridge_addr)
                `ADDR_LIVES:       lives       <= bridge_wr_data[1:0];
                `ADDR_DIFFICULTY:  difficulty  <= bridge_wr_data[2:0];
                `ADDR_BONUS:       bonus       <= bridge_wr_data[2:0];
                `ADDR_DEMO_SOUNDS: demo_sounds <= bridge_wr_data[0];
                `ADDR_SNAC_ENABLE: snac_ena_q  <= bridge_wr_data[0];
                `ADDR_SNAC_CONFIG: begin
                    cont_type_q   <= bridge_wr_data[`SNAC_TYPE_LSB +: 5];
                    assign_mode_q <= assign_mode_t'(bridge_wr_data[`SNAC_ASSIGN_LSB +: 2]);
                end
                default: ;
            endcase
        end
    end

    // read back only the snac fields
    always_comb begin
        bridge_rd_data = '0;
        case (bridge_addr)
            `ADDR_SNAC_ENABLE: bridge_rd_data[0] = snac_ena_q;
            `ADDR_SNAC_CONFIG: begin
                bridge_rd_data[`SNAC_TYPE_LSB +: 5]   = cont_type_q;
                bridge_rd_data[`SNAC_ASSIGN_LSB +: 2] = assign_mode_q;
            end
            default: ;
        endcase
    end

    assign cfg.snac_ena    = snac_ena_q;
    assign cfg.cont_type   = cont_type_q;
    assign cfg.assign_mode = assign_mode_q;
    // both analog pad types use the left stick
    assign cfg.is_analog   = (cont_type_q == `SNAC_TYPE_ANALOG_A) ||
                             (cont_type_q == `SNAC_TYPE_ANALOG_B);

    // byte-swapped already
    // hi: 00, difficulty, bonus / lo: demo, 0, lives, 0000
    assign dip_switches = {2'b00, difficulty, bonus, demo_sounds, 1'b0, lives, 4'b0000};

    ////////////////////
    // manual reset hold
    ////////////////////

    assign reset_wr = bridge_wr && (bridge_addr == `ADDR_MANUAL_RESET);

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            hold_active <= 1'b0;
            hold_cnt    <= '0;
        end else if (!hold_active) begin
            if (reset_wr) begin
                hold_active <= 1'b1;
                hold_cnt    <= HOLD_W'(`RESET_HOLD_CYCLES - 1);
            end
        end else if (hold_cnt == '0) begin
            hold_active <= 1'b0;
        end else begin
            // further reset writes ignored here
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign core_reset = reset | hold_active;

    // board reset always reaches the core
    a_reset_passes: assert property (@(posedge clk_74a) reset |-> core_reset);

    // an accepted reset write holds the core for the full count, then lets go
    a_hold_length: assert property (@(posedge clk_74a) disable iff (reset)
        (reset_wr && !hold_active) |=> core_reset [*`RESET_HOLD_CYCLES] ##1 !core_reset);

endmodule

//--- logic/player_route.sv
/*
 * player router
 * merges decoded snac players and pocket keys into p1/p2 control words
 */

`timescale 1ns/100ps

`include "arcade_input_consts.svh"

module player_route import arcade_input_pkg::*; (
    input  logic      clk_74a,
    input  logic      reset,
    snac_cfg_if.route cfg,
    input  key_word_t cont1_key,
    input  key_word_t cont2_key,
    input  key_word_t snac1,
    input  key_word_t snac2,
    output key_word_t p1_controls,
    output key_word_t p2_controls
);

    logic snac_off;

    // no snac pad configured, pocket keys only
    assign snac_off = !cfg.snac_ena || (cfg.cont_type == `SNAC_TYPE_NONE);

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else if (snac_off) begin
            p1_controls <= cont1_key;
            p2_controls <= cont2_key;
        end else begin
            case (cfg.assign_mode)
                // snac1 on p1, pocket on p2
                snac1_to_p1: begin
                    p1_controls <= snac1;
                    p2_controls <= cont1_key;
                end
                // pocket on p1, decoded snac1 on p2
                snac1_to_p2: begin
                    p1_controls <= cont1_key;
                    p2_controls <= snac1;
                end
                snac_both: begin
                    p1_controls <= snac1;
                    p2_controls <= snac2;
                end
                // both snac ports, crossed
                snac_swapped: begin
                    p1_controls <= snac2;
                    p2_controls <= snac1;
                end
                default: begin
                    p1_controls <= cont1_key;
                    p2_controls <= cont2_key;
                end
            endcase
        end
    end

    // mode comes from a bridge register, must be defined once out of reset
    a_mode_known: assert property (@(posedge clk_74a) disable iff (reset)
        !$isunknown(cfg.assign_mode));

endmodule

//--- logic/snac_cfg_if.sv
/*
 * snac configuration bundle
 * settings block drives it, decoders and player router read it
 */

`timescale 1ns/100ps

interface snac_cfg_if import arcade_input_pkg::*; ();

    logic         snac_ena;
    cont_type_t   cont_type;
    assign_mode_t assign_mode;
    // analog stick type, worked out once in the settings block
    logic         is_analog;

    modport settings_src (
        output snac_ena,
        output cont_type,
        output assign_mode,
        output is_analog
    );

    // decoders only care whether the stick replaces the d-pad
    modport decode (
        input is_analog
    );

    modport route (
        input snac_ena,
        input cont_type,
        input assign_mode
    );

endinterface

//--- logic/snac_dpad_decode.sv
/*
 * snac d-pad decoder
 * picks digital d-pad or thresholded left stick for one snac player
 */

`timescale 1ns/100ps

`include "arcade_input_consts.svh"

module snac_dpad_decode import arcade_input_pkg::*; (
    input  logic       clk_74a,
    input  logic       reset,
    snac_cfg_if.decode cfg,
    input  key_word_t  snac_btn,
    input  joy_word_t  snac_joy,
    output key_word_t  decoded_btn
);

    axis_t stick_x;
    axis_t stick_y;
    logic  stick_up;
    logic  stick_down;
    logic  stick_left;
    logic  stick_right;

    // left stick only
    assign stick_x = snac_joy[7:0];
    assign stick_y = snac_joy[15:8];

    // 0x00 up/left, 0xff down/right
    // threshold values themselves count as centre
    assign stick_up    = stick_y < `STICK_LOW;
    assign stick_down  = stick_y > `STICK_HIGH;
    assign stick_left  = stick_x < `STICK_LOW;
    assign stick_right = stick_x > `STICK_HIGH;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            decoded_btn <= '0;
        end else if (cfg.is_analog) begin
            // buttons pass, directions from the stick
            decoded_btn <= {snac_btn[15:4], stick_right, stick_left, stick_down, stick_up};
        end else begin
            decoded_btn <= snac_btn;
        end
    end

endmodule

//--- project.f
+incdir+include
logic/arcade_input_pkg.sv
logic/snac_cfg_if.sv
logic/core_settings.sv
logic/snac_dpad_decode.sv
logic/player_route.sv
logic/arcade_controls.sv
logic/arcade_input_top.sv
dv/arcade_input_tb.sv
